/* renameStage_params.svh */
`ifndef RENAME_STAGE_PARAMS_SVH
`define RENAME_STAGE_PARAMS_SVH

// Architectural register file
`define REG_NUM    32
`define NAME_W     5

// Data, immediate and PC width
`define DATA_W     32

// Rename tag width, tag 0 is reserved for "value ready"
`define TAG_W      4

// Reorder buffer entries, power of two below 2**TAG_W
`define ROB_DEPTH  8

`endif

/* renamePkg.sv */
`include "renameStage_params.svh"

package renamePkg;

    typedef logic [`NAME_W-1:0] regName_t;
    typedef logic [`DATA_W-1:0] data_t;
    typedef logic [`TAG_W-1:0]  tag_t;     // 0 means no pending producer

    typedef enum logic [5:0] {
        ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU,
        ADDI, ANDI, ORI, XORI, SLTI, SLLI, SRLI, SRAI,
        LW, SW, SB, SH,
        BEQ, BNE, BLT, BGE,
        LUI, AUIPC, JAL, JALR, ILLEGAL
    } op_t;

    // Ops that produce a register result
    function automatic logic writesRd(op_t op);
        case (op)
            SW, SB, SH,
            BEQ, BNE, BLT, BGE,
            ILLEGAL: return 1'b0;
            default: return 1'b1;
        endcase
    endfunction

endpackage

/* instDecode.sv */
`timescale 1ns/10ps

module instDecode (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                instValid,
    input  renamePkg::data_t    instWord,
    input  renamePkg::data_t    instPc,
    input  logic                instPredTaken,
    output logic                instReady,
    output logic                decValid,
    output renamePkg::regName_t decRs1,
    output renamePkg::regName_t decRs2,
    output renamePkg::regName_t decRd,
    output renamePkg::op_t      decOp,
    output renamePkg::data_t    decImm,
    output renamePkg::data_t    decPc,
    output logic                decPredTaken,
    input  logic                decReady
);
    import renamePkg::*;

    localparam logic [6:0] opcLui    = 7'b0110111;
    localparam logic [6:0] opcAuipc  = 7'b0010111;
    localparam logic [6:0] opcJal    = 7'b1101111;
    localparam logic [6:0] opcJalr   = 7'b1100111;
    localparam logic [6:0] opcBranch = 7'b1100011;
    localparam logic [6:0] opcLoad   = 7'b0000011;
    localparam logic [6:0] opcStore  = 7'b0100011;
    localparam logic [6:0] opcOpImm  = 7'b0010011;
    localparam logic [6:0] opcOp     = 7'b0110011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    data_t      immI;
    data_t      immS;
    data_t      immB;
    data_t      immU;
    data_t      immJ;
    data_t      immSh;
    op_t        nextOp;
    data_t      nextImm;
    logic       useRs1;
    logic       useRs2;
    logic       take;

    assign opcode = instWord[6:0];     // Compressed words fall to default
    assign funct3 = instWord[14:12];
    assign funct7 = instWord[31:25];

    assign immI  = {{20{instWord[31]}}, instWord[31:20]};
    assign immS  = {{20{instWord[31]}}, instWord[31:25], instWord[11:7]};
    assign immB  = {{19{instWord[31]}}, instWord[31], instWord[7], instWord[30:25],
                    instWord[11:8], 1'b0};
    assign immU  = {instWord[31:12], 12'b0};
    assign immJ  = {{11{instWord[31]}}, instWord[31], instWord[19:12], instWord[20],
                    instWord[30:21], 1'b0};
    assign immSh = {27'b0, instWord[24:20]};    // Shift amount only

    always_comb begin
        nextOp  = ILLEGAL;
        nextImm = '0;
        case (opcode)
            opcLui: begin
                nextOp  = LUI;
                nextImm = immU;
            end
            opcAuipc: begin
                nextOp  = AUIPC;
                nextImm = immU;
            end
            opcJal: begin
                nextOp  = JAL;
                nextImm = immJ;
            end
            opcJalr: begin
                nextImm = immI;
                if (funct3 == 3'b000) nextOp = JALR;
            end
            opcBranch: begin
                nextImm = immB;
                case (funct3)
                    3'b000:  nextOp = BEQ;
                    3'b001:  nextOp = BNE;
                    3'b100:  nextOp = BLT;
                    3'b101:  nextOp = BGE;
                    default: nextOp = ILLEGAL;   // No unsigned branches
                endcase
            end
            opcLoad: begin
                nextImm = immI;
                if (funct3 == 3'b010) nextOp = LW;
            end
            opcStore: begin
                nextImm = immS;
                case (funct3)
                    3'b000:  nextOp = SB;
                    3'b001:  nextOp = SH;
                    3'b010:  nextOp = SW;
                    default: nextOp = ILLEGAL;
                endcase
            end
            opcOpImm: begin
                nextImm = immI;
                case (funct3)
                    3'b000: nextOp = ADDI;
                    3'b010: nextOp = SLTI;
                    3'b100: nextOp = XORI;
                    3'b110: nextOp = ORI;
                    3'b111: nextOp = ANDI;
                    3'b001: begin
                        nextImm = immSh;
                        if (funct7 == 7'b0000000) nextOp = SLLI;
                    end
                    3'b101: begin
                        nextImm = immSh;
                        if (funct7 == 7'b0000000) nextOp = SRLI;
                        else if (funct7 == 7'b0100000) nextOp = SRAI;
                    end
                    default: nextOp = ILLEGAL;   // SLTIU
                endcase
            end
            opcOp: begin
                case ({funct7, funct3})
                    10'b0000000_000: nextOp = ADD;
                    10'b0100000_000: nextOp = SUB;
                    10'b0000000_001: nextOp = SLL;
                    10'b0000000_010: nextOp = SLT;
                    10'b0000000_011: nextOp = SLTU;
                    10'b0000000_100: nextOp = XOR;
                    10'b0000000_101: nextOp = SRL;
                    10'b0100000_101: nextOp = SRA;
                    10'b0000000_110: nextOp = OR;
                    10'b0000000_111: nextOp = AND;
                    default:         nextOp = ILLEGAL;
                endcase
            end
            default: nextOp = ILLEGAL;           // CSR, fence and others
        endcase
        if (nextOp == ILLEGAL) nextImm = '0;
    end

    assign useRs1 = !(nextOp inside {LUI, AUIPC, JAL, ILLEGAL});
    assign useRs2 = nextOp inside {ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU,
                                   SW, SB, SH, BEQ, BNE, BLT, BGE};

    assign instReady = !decValid || decReady;
    assign take      = instValid && instReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            decValid     <= 1'b0;
            decRs1       <= '0;
            decRs2       <= '0;
            decRd        <= '0;
            decOp        <= ADD;       // Zero encoding
            decImm       <= '0;
            decPc        <= '0;
            decPredTaken <= 1'b0;
        end else if (flush) begin
            decValid <= 1'b0;
        end else if (take) begin
            decValid     <= 1'b1;
            decRs1       <= useRs1 ? instWord[19:15] : '0;
            decRs2       <= useRs2 ? instWord[24:20] : '0;
            decRd        <= writesRd(nextOp) ? instWord[11:7] : '0;
            decOp        <= nextOp;
            decImm       <= nextImm;
            decPc        <= instPc;
            decPredTaken <= instPredTaken;
        end else if (decReady) begin
            decValid <= 1'b0;
        end
    end

endmodule

/* regFile.sv */
`timescale 1ns/10ps
`include "renameStage_params.svh"

module regFile (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                decValid,
    input  renamePkg::regName_t decRs1,
    input  renamePkg::regName_t decRs2,
    input  renamePkg::regName_t decRd,
    input  renamePkg::op_t      decOp,
    input  renamePkg::data_t    decImm,
    input  renamePkg::data_t    decPc,
    input  logic                decPredTaken,
    output logic                decReady,
    output logic                allocReq,
    output renamePkg::data_t    allocPc,
    output renamePkg::regName_t allocRd,
    input  renamePkg::tag_t     allocTag,
    input  logic                allocReady,
    input  logic                commitValid,
    input  renamePkg::regName_t commitRd,
    input  renamePkg::tag_t     commitTag,
    input  renamePkg::data_t    commitData,
    output logic                dpValid,
    input  logic                dpReady,
    output renamePkg::data_t    rs1Val,
    output renamePkg::data_t    rs2Val,
    output renamePkg::tag_t     rs1Tag,
    output renamePkg::tag_t     rs2Tag,
    output renamePkg::tag_t     rdTag,
    output renamePkg::regName_t rdName,
    output renamePkg::op_t      op,
    output renamePkg::data_t    imm,
    output renamePkg::data_t    pc,
    output logic                predTaken
);
    import renamePkg::*;

    data_t regVal [`REG_NUM];
    tag_t  regTag [`REG_NUM];

    logic  accept;
    logic  renameEn;
    logic  rs1Hit;
    logic  rs2Hit;
    data_t rs1ValNext;
    data_t rs2ValNext;
    tag_t  rs1TagNext;
    tag_t  rs2TagNext;

    assign decReady = (!dpValid || dpReady) && allocReady;
    assign accept   = decValid && decReady;
    assign renameEn = accept && writesRd(decOp) && (decRd != '0);

    assign allocReq = accept;
    assign allocPc  = decPc;
    assign allocRd  = decRd;

    // Commit bypass, only while the register still waits on that tag
    assign rs1Hit = commitValid && (commitRd == decRs1) && (regTag[decRs1] == commitTag);
    assign rs2Hit = commitValid && (commitRd == decRs2) && (regTag[decRs2] == commitTag);

    assign rs1ValNext = rs1Hit ? commitData : regVal[decRs1];
    assign rs2ValNext = rs2Hit ? commitData : regVal[decRs2];
    assign rs1TagNext = rs1Hit ? '0 : regTag[decRs1];
    assign rs2TagNext = rs2Hit ? '0 : regTag[decRs2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regVal[i] <= '0;
                regTag[i] <= '0;
            end
        end else begin
            if (commitValid && (commitRd != '0)) begin
                regVal[commitRd] <= commitData;          // Written even on flush
                if (regTag[commitRd] == commitTag) regTag[commitRd] <= '0;
            end
            if (flush) begin
                for (int i = 0; i < `REG_NUM; i++) begin
                    regTag[i] <= '0;
                end
            end else if (renameEn) begin
                regTag[decRd] <= allocTag;               // Beats a same-cycle retire
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dpValid   <= 1'b0;
            rs1Val    <= '0;
            rs2Val    <= '0;
            rs1Tag    <= '0;
            rs2Tag    <= '0;
            rdTag     <= '0;
            rdName    <= '0;
            op        <= ADD;
            imm       <= '0;
            pc        <= '0;
            predTaken <= 1'b0;
        end else if (flush) begin
            dpValid <= 1'b0;
        end else if (accept) begin
            dpValid   <= 1'b1;
            rs1Val    <= rs1ValNext;
            rs2Val    <= rs2ValNext;
            rs1Tag    <= rs1TagNext;
            rs2Tag    <= rs2TagNext;
            rdTag     <= allocTag;                       // Result tag, even without rd
            rdName    <= decRd;
            op        <= decOp;
            imm       <= decImm;
            pc        <= decPc;
            predTaken <= decPredTaken;
        end else if (dpReady) begin
            dpValid <= 1'b0;
        end
    end

endmodule

/* reorderBuffer.sv */
`timescale 1ns/10ps
`include "renameStage_params.svh"

module reorderBuffer (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                allocReq,
    input  renamePkg::data_t    allocPc,
    input  renamePkg::regName_t allocRd,
    output logic                allocReady,
    output renamePkg::tag_t     allocTag,
    input  logic                resultValid,
    input  renamePkg::tag_t     resultTag,
    input  renamePkg::data_t    resultData,
    output logic                commitValid,
    output renamePkg::regName_t commitRd,
    output renamePkg::tag_t     commitTag,
    output renamePkg::data_t    commitData,
    output renamePkg::data_t    commitPc
);
    import renamePkg::*;

    localparam int PtrW = $clog2(`ROB_DEPTH);

    typedef logic [PtrW-1:0] ptr_t;
    typedef logic [PtrW:0]   cnt_t;

    data_t    entryPc   [`ROB_DEPTH];
    regName_t entryRd   [`ROB_DEPTH];
    data_t    entryData [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] entryDone;

    ptr_t head;
    ptr_t tail;
    ptr_t resultIdx;
    cnt_t count;
    logic doAlloc;
    logic doResult;

    assign allocReady = (count != cnt_t'(`ROB_DEPTH));
    assign allocTag   = tag_t'(tail) + tag_t'(1);       // Slot k carries tag k+1
    assign doAlloc    = allocReq && allocReady;

    assign resultIdx  = ptr_t'(resultTag - tag_t'(1));
    assign doResult   = resultValid && (resultTag != '0);

    assign commitValid = (count != '0) && entryDone[head];
    assign commitRd    = entryRd[head];
    assign commitTag   = tag_t'(head) + tag_t'(1);
    assign commitData  = entryData[head];
    assign commitPc    = entryPc[head];

    always_ff @(posedge clk) begin
        if (rst) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            entryDone <= '0;
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                entryPc[i]   <= '0;
                entryRd[i]   <= '0;
                entryData[i] <= '0;
            end
        end else if (flush) begin
            head      <= tail;          // Tags resume from the current tail
            count     <= '0;
            entryDone <= '0;
        end else begin
            if (doAlloc) begin
                entryPc[tail]   <= allocPc;
                entryRd[tail]   <= allocRd;
                entryDone[tail] <= 1'b0;
                tail            <= tail + ptr_t'(1);
            end
            if (doResult) begin
                entryData[resultIdx] <= resultData;
                entryDone[resultIdx] <= 1'b1;
            end
            if (commitValid) begin
                entryDone[head] <= 1'b0;
                head            <= head + ptr_t'(1);
            end
            case ({doAlloc, commitValid})
                2'b10:   count <= count + cnt_t'(1);
                2'b01:   count <= count - cnt_t'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

/* renameStage.sv */
`timescale 1ns/10ps

module renameStage (
    input  logic                clk,
    input  logic                rst,
    input  logic                instValid,
    input  renamePkg::data_t    instWord,
    input  renamePkg::data_t    instPc,
    input  logic                instPredTaken,
    output logic                instReady,
    output logic                dpValid,
    input  logic                dpReady,
    output renamePkg::data_t    rs1Val,
    output renamePkg::data_t    rs2Val,
    output renamePkg::tag_t     rs1Tag,
    output renamePkg::tag_t     rs2Tag,
    output renamePkg::regName_t rdName,
    output renamePkg::tag_t     rdTag,
    output renamePkg::op_t      op,
    output renamePkg::data_t    imm,
    output renamePkg::data_t    pc,
    output logic                predTaken,
    input  logic                resultValid,
    input  renamePkg::tag_t     resultTag,
    input  renamePkg::data_t    resultData,
    input  logic                flush,
    output logic                commitValid,
    output renamePkg::regName_t commitRd,
    output renamePkg::tag_t     commitTag,
    output renamePkg::data_t    commitData,
    output renamePkg::data_t    commitPc
);
    import renamePkg::*;

    // Decoder to register file
    logic     decValid;
    logic     decReady;
    regName_t decRs1;
    regName_t decRs2;
    regName_t decRd;
    op_t      decOp;
    data_t    decImm;
    data_t    decPc;
    logic     decPredTaken;

    // Tag allocation
    logic     allocReq;
    logic     allocReady;
    data_t    allocPc;
    regName_t allocRd;
    tag_t     allocTag;

    instDecode decoder (.*);

    regFile regs (.*);              // Also sinks the commit bus

    reorderBuffer rob (.*);

endmodule

/* tbRenameStage.sv */
`timescale 1ns/10ps

module tbRenameStage;
    import renamePkg::*;

    localparam int waitLimit = 200;

    typedef struct {
        int          index;
        logic [31:0] op;
        logic [31:0] imm;
        logic [31:0] rd;
        logic [31:0] rdTag;
        logic [31:0] rs1Tag;
        logic [31:0] rs1Val;
        logic [31:0] rs2Tag;
        logic [31:0] rs2Val;
        logic [31:0] pc;
        logic [31:0] pred;
    } dispExp_t;

    typedef struct {
        logic [31:0] rd;
        logic [31:0] tag;
        logic [31:0] data;
        logic [31:0] pc;
    } commitExp_t;

    logic     clk = 1'b0;
    logic     rst = 1'b1;
    logic     instValid = 1'b0;
    data_t    instWord = '0;
    data_t    instPc = '0;
    logic     instPredTaken = 1'b0;
    logic     instReady;
    logic     dpValid;
    logic     dpReady = 1'b0;
    data_t    rs1Val;
    data_t    rs2Val;
    tag_t     rs1Tag;
    tag_t     rs2Tag;
    regName_t rdName;
    tag_t     rdTag;
    op_t      op;
    data_t    imm;
    data_t    pc;
    logic     predTaken;
    logic     resultValid = 1'b0;
    tag_t     resultTag = '0;
    data_t    resultData = '0;
    logic     flush = 1'b0;
    logic     commitValid;
    regName_t commitRd;
    tag_t     commitTag;
    data_t    commitData;
    data_t    commitPc;

    dispExp_t   dispQ[$];
    commitExp_t commitQ[$];
    int sentCount = 0;
    int dispCount = 0;
    int commitCount = 0;
    int commitExpCount = 0;

    renameStage DUT (.*);

    always #2 clk = ~clk;

    initial begin
        int unsigned draw;
        draw = $urandom(32'h9dce9956);                      // Seeds this stream once
        forever begin
            @(negedge clk);
            dpReady = (draw % 4) != 0;                      // Random stalls
            draw = $urandom;
        end
    end

    task automatic failRun(input string what);
        $display("*** FAILED ***");
        $fatal(1, "%s", what);
    endtask

    task automatic checkEq(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    always @(posedge clk) begin
        dispExp_t e;
        if (!rst && dpValid && dpReady) begin
            if (dispQ.size() == 0) begin
                failRun("A dispatch came out with no instruction left to expect");
            end else begin
                e = dispQ.pop_front();
                checkEq($sformatf("inst %0d op", e.index), e.op, 32'(op));
                checkEq($sformatf("inst %0d imm", e.index), e.imm, imm);
                checkEq($sformatf("inst %0d rdName", e.index), e.rd, 32'(rdName));
                checkEq($sformatf("inst %0d rdTag", e.index), e.rdTag, 32'(rdTag));
                checkEq($sformatf("inst %0d rs1Tag", e.index), e.rs1Tag, 32'(rs1Tag));
                checkEq($sformatf("inst %0d rs2Tag", e.index), e.rs2Tag, 32'(rs2Tag));
                if (e.rs1Tag == 0)                                      // Value only when ready
                    checkEq($sformatf("inst %0d rs1Val", e.index), e.rs1Val, rs1Val);
                if (e.rs2Tag == 0)
                    checkEq($sformatf("inst %0d rs2Val", e.index), e.rs2Val, rs2Val);
                checkEq($sformatf("inst %0d pc", e.index), e.pc, pc);
                checkEq($sformatf("inst %0d predTaken", e.index), e.pred, 32'(predTaken));
                dispCount++;
            end
        end
    end

    always @(posedge clk) begin
        commitExp_t c;
        if (!rst && commitValid) begin
            if (commitQ.size() == 0) begin
                failRun("A commit came out that the pattern file does not expect");
            end else begin
                c = commitQ.pop_front();
                checkEq($sformatf("commit %0d rd", commitCount + 1), c.rd, 32'(commitRd));
                checkEq($sformatf("commit %0d tag", commitCount + 1), c.tag, 32'(commitTag));
                checkEq($sformatf("commit %0d data", commitCount + 1), c.data, commitData);
                checkEq($sformatf("commit %0d pc", commitCount + 1), c.pc, commitPc);
                commitCount++;
            end
        end
    end

    task automatic clearPulses();
        instValid   = 1'b0;
        resultValid = 1'b0;
        flush       = 1'b0;
    endtask

    // Called on a falling edge, returns on one
    task automatic waitDispatches(input int n);
        int cycles;
        cycles = 0;
        while (dispCount < n) begin
            if (cycles >= waitLimit) begin
                failRun("Timed out waiting for dispatches");
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    task automatic waitCommits(input int n);
        int cycles;
        cycles = 0;
        while (commitCount < n) begin
            if (cycles >= waitLimit) begin
                failRun("Timed out waiting for commits");
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    task automatic sendInst(input logic [31:0] word, input logic [31:0] addr,
                            input logic [31:0] pred);
        int cycles;
        @(negedge clk);
        clearPulses();
        waitCommits(commitExpCount);
        instValid     = 1'b1;
        instWord      = word;
        instPc        = addr;
        instPredTaken = pred[0];
        cycles = 0;
        @(posedge clk);
        while (!instReady) begin
            if (cycles >= waitLimit) begin
                failRun("Timed out waiting for the DUT to take an instruction");
            end else begin
                @(posedge clk);
                cycles++;
            end
        end
        sentCount++;
    endtask

    task automatic sendResult(input logic [31:0] tag, input logic [31:0] data,
                              input int need);
        @(negedge clk);
        clearPulses();
        waitDispatches(need);
        resultValid = 1'b1;
        resultTag   = tag_t'(tag);
        resultData  = data;
        @(posedge clk);
    endtask

    task automatic expectBlocked(input int need, input logic [31:0] ready);
        @(negedge clk);
        clearPulses();
        waitDispatches(need);
        @(posedge clk);
        checkEq("instReady with full buffer", ready, 32'(instReady));
    endtask

    task automatic flushPipeline();
        @(negedge clk);
        clearPulses();
        waitDispatches(sentCount);
        waitCommits(commitExpCount);
        flush = 1'b1;
        @(posedge clk);
    endtask

    initial begin
        int          fd;
        int          cnt;
        string       line;
        string       lines[$];
        dispExp_t    e;
        commitExp_t  c;
        logic [31:0] f [11];
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        fd = $fopen("renameStage_patterns.txt", "r");
        if (fd == 0) failRun("Could not open the pattern file");
        // Results can retire before their commit lines are reached
        while ($fgets(line, fd) != 0) begin
            lines.push_back(line);
            if (line.getc(0) == "C") begin
                cnt = $sscanf(line, "C %h %h %h %h", f[0], f[1], f[2], f[3]);
                if (cnt != 4) failRun("Malformed commit record");
                c.rd   = f[0];
                c.tag  = f[1];
                c.data = f[2];
                c.pc   = f[3];
                commitQ.push_back(c);
            end
        end
        $fclose(fd);
        foreach (lines[i]) begin
            line = lines[i];
            case (line.getc(0))
                "I": begin
                    cnt = $sscanf(line, "I %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1],
                                  f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
                    if (cnt != 11) failRun("Malformed instruction record");
                    e.index  = sentCount + 1;
                    e.pc     = f[1];
                    e.pred   = f[2];
                    e.op     = f[3];
                    e.imm    = f[4];
                    e.rd     = f[5];
                    e.rdTag  = f[6];
                    e.rs1Tag = f[7];
                    e.rs1Val = f[8];
                    e.rs2Tag = f[9];
                    e.rs2Val = f[10];
                    dispQ.push_back(e);
                    sendInst(f[0], f[1], f[2]);
                end
                "R": begin
                    cnt = $sscanf(line, "R %h %h %d", f[0], f[1], f[2]);
                    if (cnt != 3) failRun("Malformed result record");
                    sendResult(f[0], f[1], int'(f[2]));
                end
                "C": commitExpCount++;
                "W": begin
                    cnt = $sscanf(line, "W %d %h", f[0], f[1]);
                    if (cnt != 2) failRun("Malformed full-buffer record");
                    expectBlocked(int'(f[0]), f[1]);
                end
                "F": flushPipeline();
                default: ;                                  // Comments and blank lines
            endcase
        end
        @(negedge clk);
        clearPulses();
        waitDispatches(sentCount);
        waitCommits(commitExpCount);
        repeat (10) @(negedge clk);                         // Catch stray commits
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* renameStage.f */
+incdir+.
renamePkg.sv
instDecode.sv
regFile.sv
reorderBuffer.sv
renameStage.sv
tbRenameStage.sv

/* Makefile */
.PHONY: sim clean

TOP = tbRenameStage

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f renameStage.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* renameStage_patterns.txt */
# I word pc pred op imm rdName rdTag rs1Tag rs1Val rs2Tag rs2Val | R tag data dispatchesFirst
# C rd tag data pc | W dispatchesFirst instReady | F   (all hex except decimal counts)
I 00500093 00000100 0 0a 00000005 01 1 0 00000000 0 00000000
I 00108133 00000104 0 00 00000000 02 2 1 00000000 1 00000000
I 0020a423 00000108 0 13 00000008 00 3 1 00000000 2 00000000
I fe208ce3 0000010c 1 16 fffffff8 00 4 1 00000000 2 00000000
I 123451b7 00000110 0 1a 12345000 03 5 0 00000000 0 00000000
I 010000ef 00000114 0 1c 00000010 01 6 0 00000000 0 00000000
I fff0c213 00000118 0 0d ffffffff 04 7 6 00000000 0 00000000
I 00000073 0000011c 0 1e 00000000 00 8 0 00000000 0 00000000
# Buffer full, next add waits in the decoder
I 004102b3 00000120 0 00 00000000 05 1 0 0000000a 7 00000000
W 8 0
R 3 deadbeef 8
R 2 0000000a 8
R 1 00000005 8
C 01 1 00000005 00000100
C 02 2 0000000a 00000104
C 00 3 deadbeef 00000108
I 00110333 00000124 0 00 00000000 06 2 0 0000000a 6 00000000
I 00700013 00000128 0 0a 00000007 00 3 0 00000000 0 00000000
R 6 00000118 11
R 5 12345000 11
R 4 00000000 11
R 8 0000abcd 11
R 7 fffffee7 11
C 00 4 00000000 0000010c
C 03 5 12345000 00000110
C 01 6 00000118 00000114
C 04 7 fffffee7 00000118
C 00 8 0000abcd 0000011c
I 000003b3 0000012c 0 00 00000000 07 4 0 00000000 0 00000000
R 2 00000122 12
R 1 fffffef1 12
R 4 00000000 12
R 3 00000007 12
C 05 1 fffffef1 00000120
C 06 2 00000122 00000124
C 00 3 00000007 00000128
C 07 4 00000000 0000012c
I 40428433 00000130 0 01 00000000 08 5 0 fffffef1 0 fffffee7
I ffc1a483 00000134 0 12 fffffffc 09 6 0 12345000 0 00000000
I 4034d513 00000138 0 11 00000003 0a 7 6 00000000 0 00000000
R 5 0000000a 15
C 08 5 0000000a 00000130
R 7 0000dead 15
F
# Tags restart at slot 7
I 00a405b3 00000200 0 00 00000000 0b 8 0 0000000a 0 00000000
I 00f4f613 00000204 0 0b 0000000f 0c 1 0 00000000 0 00000000
I 00001697 00000208 0 1b 00001000 0d 2 0 00000000 0 00000000
I 000580e7 0000020c 0 1d 00000000 01 3 8 00000000 0 00000000
I 00061863 00000210 1 17 00000010 00 4 1 00000000 0 00000000
R 1 00000000 20
R 8 0000000a 20
C 0b 8 0000000a 00000200
C 0c 1 00000000 00000204
R 2 00001208 20
C 0d 2 00001208 00000208
R 3 00000210 20
C 01 3 00000210 0000020c
R 4 00000000 20
C 00 4 00000000 00000210
I 00008733 00000214 0 00 00000000 0e 5 0 00000210 0 00000000
